/* build.f */
+incdir+hdl
hdl/eeprom_pkg.sv
hdl/eeprom_wr.sv
hdl/sda_shifter.sv
hdl/eeprom_top.sv
testbench/eeprom_model.sv
testbench/eeprom_checker.sv
testbench/tb_eeprom.sv

/* hdl/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // operations handed to the bus shifter
    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_send,
        op_recv
    } shift_op_e;

    typedef enum logic [3:0] {
        idle,
        write_start,
        ctrl_write,
        addr_write,
        data_write,
        read_start,
        ctrl_read,
        data_read,
        stop,
        done
    } seq_state_e;

    // control byte, built by fields and shifted out as a plain byte
    typedef union packed {
        struct packed {
            logic [3:0] dev_code;
            logic [2:0] block;    // addr[10:8]
            logic       rw;       // 1 = read
        } fields;
        logic [7:0] raw;
    } ctrl_byte_u;

endpackage

`default_nettype wire

/* hdl/eeprom_settings.svh */
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// 24C16 geometry, 2K bytes
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

// device type code in the upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// CLK cycles per SCL half period, at least 2
`define SCL_HALF_CYCLES 2

`endif

/* hdl/eeprom_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_settings.svh"

module eeprom_top
(
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        wr,
    input  wire                        rd,
    input  wire [`EEPROM_ADDR_W-1:0]   addr,
    input  wire [`EEPROM_DATA_W-1:0]   wr_data,
    output logic [`EEPROM_DATA_W-1:0]  rd_data,
    output logic                       ack,
    output logic                       scl,
    output logic                       sda_low,
    input  wire                        sda_in
);

    logic                       op_req;
    logic                       op_ack;
    eeprom_pkg::shift_op_e      op;
    logic [`EEPROM_DATA_W-1:0]  tx_byte;
    logic [`EEPROM_DATA_W-1:0]  rx_byte;

    eeprom_wr i_eeprom_wr (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .op_req  (op_req),
        .op      (op),
        .tx_byte (tx_byte),
        .op_ack  (op_ack),
        .rx_byte (rx_byte)
    );

    sda_shifter i_sda_shifter (
        .CLK     (CLK),
        .RESET   (RESET),
        .op_req  (op_req),
        .op      (op),
        .tx_byte (tx_byte),
        .op_ack  (op_ack),
        .rx_byte (rx_byte),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

`default_nettype wire

/* hdl/eeprom_wr.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_settings.svh"

module eeprom_wr
(
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        wr,
    input  wire                        rd,
    input  wire [`EEPROM_ADDR_W-1:0]   addr,
    input  wire [`EEPROM_DATA_W-1:0]   wr_data,
    output logic [`EEPROM_DATA_W-1:0]  rd_data,
    output logic                       ack,
    output logic                       op_req,
    output eeprom_pkg::shift_op_e      op,
    output logic [`EEPROM_DATA_W-1:0]  tx_byte,
    input  wire                        op_ack,
    input  wire [`EEPROM_DATA_W-1:0]   rx_byte
);

    eeprom_pkg::seq_state_e     state;
    eeprom_pkg::seq_state_e     next_state;
    eeprom_pkg::ctrl_byte_u     ctrl;

    logic                       is_read;    // latched request type
    logic                       wait_rel;   // op acked, waiting for op_ack to drop
    logic                       start_req;
    logic [`EEPROM_ADDR_W-1:0]  addr_q;
    logic [`EEPROM_DATA_W-1:0]  data_q;

    assign start_req = wr || rd;

    // one cycle pulse, rd_data is already valid here
    assign ack = (state == eeprom_pkg::done);

    always_comb
    begin
        ctrl.fields.dev_code = `EEPROM_DEV_CODE;
        ctrl.fields.block    = addr_q[`EEPROM_ADDR_W-1 -: 3];
        ctrl.fields.rw       = (state == eeprom_pkg::ctrl_read); // dummy write uses rw 0
    end

    // op and byte follow the state, so they are stable while op_req is high
    always_comb
    begin
        op      = eeprom_pkg::op_send;
        tx_byte = ctrl.raw;
        case (state)
            eeprom_pkg::write_start,
            eeprom_pkg::read_start:
            begin
                op = eeprom_pkg::op_start;
            end
            eeprom_pkg::addr_write:
            begin
                tx_byte = addr_q[7:0];
            end
            eeprom_pkg::data_write:
            begin
                tx_byte = data_q;
            end
            eeprom_pkg::data_read:
            begin
                op = eeprom_pkg::op_recv;
            end
            eeprom_pkg::stop:
            begin
                op = eeprom_pkg::op_stop;
            end
            default:
            begin
                op = eeprom_pkg::op_send; // control bytes
            end
        endcase
    end

    always_comb
    begin
        case (state)
            eeprom_pkg::write_start: next_state = eeprom_pkg::ctrl_write;
            eeprom_pkg::ctrl_write:  next_state = eeprom_pkg::addr_write;
            eeprom_pkg::addr_write:
            begin
                // read continues after the dummy write
                if (is_read)
                    next_state = eeprom_pkg::read_start;
                else
                    next_state = eeprom_pkg::data_write;
            end
            eeprom_pkg::data_write:  next_state = eeprom_pkg::stop;
            eeprom_pkg::read_start:  next_state = eeprom_pkg::ctrl_read;
            eeprom_pkg::ctrl_read:   next_state = eeprom_pkg::data_read;
            eeprom_pkg::data_read:   next_state = eeprom_pkg::stop;
            eeprom_pkg::stop:        next_state = eeprom_pkg::done;
            default:                 next_state = eeprom_pkg::idle;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_pkg::idle;
            op_req   <= 1'b0;
            wait_rel <= 1'b0;
            is_read  <= 1'b0;
            rd_data  <= '0;
        end
        else
        begin
            case (state)
                eeprom_pkg::idle:
                begin
                    if (start_req)
                    begin
                        is_read <= !wr;   // wr wins
                        state   <= eeprom_pkg::write_start;
                    end
                end
                eeprom_pkg::done:
                begin
                    state <= eeprom_pkg::idle;
                end
                default:
                begin
                    // four-phase handshake, one op per state
                    if (!op_req && !wait_rel)
                    begin
                        op_req <= 1'b1;
                    end
                    else if (op_req && op_ack)
                    begin
                        op_req   <= 1'b0;
                        wait_rel <= 1'b1;
                        if (state == eeprom_pkg::data_read)
                            rd_data <= rx_byte;
                    end
                    else if (wait_rel && !op_ack)
                    begin
                        wait_rel <= 1'b0;
                        state    <= next_state;
                    end
                end
            endcase
        end
    end

    // host holds addr and data for the whole transaction
    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::idle && start_req)
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/sda_shifter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_settings.svh"

module sda_shifter
(
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        op_req,
    input  wire eeprom_pkg::shift_op_e op,
    input  wire [`EEPROM_DATA_W-1:0]   tx_byte,
    output logic                       op_ack,
    output logic [`EEPROM_DATA_W-1:0]  rx_byte,
    output logic                       scl,
    output logic                       sda_low,
    input  wire                        sda_in
);

    localparam int HALF        = `SCL_HALF_CYCLES;
    localparam int CNT_W       = $clog2(HALF);
    localparam int BYTE_HALVES = 2 * `EEPROM_DATA_W;
    localparam int HALF_W      = $clog2(BYTE_HALVES);

    eeprom_pkg::shift_op_e      cur_op;
    logic                       busy;
    logic [CNT_W-1:0]           cnt;
    logic [HALF_W-1:0]          half;       // half period index within the op
    logic [`EEPROM_DATA_W-1:0]  tx_shift;
    logic [`EEPROM_DATA_W-1:0]  rx_shift;

    logic accept;
    logic half_end;
    logic last_half;
    logic edge_slot;
    logic sda_slot;
    logic is_byte_op;

    assign accept     = !busy && !op_ack && op_req;
    assign half_end   = (cnt == CNT_W'(HALF - 1));
    assign edge_slot  = (cnt == '0);        // scl moves here
    assign sda_slot   = (cnt == CNT_W'(1)); // sda moves one CLK later, scl already low
    assign is_byte_op = (cur_op == eeprom_pkg::op_send) || (cur_op == eeprom_pkg::op_recv);
    assign last_half  = is_byte_op ? (half == HALF_W'(BYTE_HALVES - 1)) : (half == HALF_W'(2));
    assign rx_byte    = rx_shift;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_ack  <= 1'b0;
            cur_op  <= eeprom_pkg::op_start;
            cnt     <= '0;
            half    <= '0;
            scl     <= 1'b1;    // idle bus
            sda_low <= 1'b0;
        end
        else if (!busy)
        begin
            if (op_ack)
            begin
                if (!op_req)
                    op_ack <= 1'b0;
            end
            else if (op_req)
            begin
                busy   <= 1'b1;
                cur_op <= op;
                cnt    <= '0;
                half   <= '0;
            end
        end
        else
        begin
            if (edge_slot)
            begin
                // start and stop move sda in the third half, scl held high
                if (!is_byte_op && half == HALF_W'(2))
                    sda_low <= (cur_op == eeprom_pkg::op_start);
                else
                    scl <= half[0];
            end

            if (sda_slot && !half[0])
            begin
                case (cur_op)
                    eeprom_pkg::op_start:
                    begin
                        if (half == '0)
                            sda_low <= 1'b0;    // sda high before it falls
                    end
                    eeprom_pkg::op_stop:
                    begin
                        if (half == '0)
                            sda_low <= 1'b1;
                    end
                    eeprom_pkg::op_send:
                    begin
                        sda_low <= !tx_shift[`EEPROM_DATA_W-1]; // msb first
                    end
                    default:
                    begin
                        sda_low <= 1'b0;    // slave drives
                    end
                endcase
            end

            if (half_end)
            begin
                cnt <= '0;
                if (last_half)
                begin
                    busy   <= 1'b0;
                    op_ack <= 1'b1;
                end
                else
                begin
                    half <= half + 1'b1;
                end
            end
            else
            begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            tx_shift <= tx_byte;
        else if (busy && sda_slot && !half[0] && cur_op == eeprom_pkg::op_send)
            tx_shift <= {tx_shift[`EEPROM_DATA_W-2:0], 1'b0};
    end

    // sample on the cycle scl rises
    always_ff @(posedge CLK)
    begin
        if (busy && edge_slot && half[0] && cur_op == eeprom_pkg::op_recv)
            rx_shift <= {rx_shift[`EEPROM_DATA_W-2:0], sda_in};
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the EEPROM controller testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_eeprom \
    --Mdir obj_dir \
    -o tb_eeprom
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_eeprom > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* testbench/eeprom_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_settings.svh"

module eeprom_checker
(
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        wr,
    input  wire                        rd,
    input  wire [`EEPROM_ADDR_W-1:0]   addr,
    input  wire [`EEPROM_DATA_W-1:0]   wr_data,
    input  wire [`EEPROM_DATA_W-1:0]   rd_data,
    input  wire                        ack,
    input  wire                        scl,
    input  wire                        sda,
    input  wire                        sda_low,
    input  wire                        ctrl_bad,
    output logic [`EEPROM_ADDR_W-1:0]  peek_addr,
    input  wire [`EEPROM_DATA_W-1:0]   peek_data,
    output int                         err_count
);

    localparam int ADDR_W = `EEPROM_ADDR_W;
    localparam int DEPTH  = 1 << ADDR_W;

    logic [7:0]         shadow [0:DEPTH-1];
    logic               scl_q;
    logic               sda_q;
    logic               ack_q;
    logic               active;
    logic               seen_req;
    logic               is_wr;
    logic [ADDR_W-1:0]  addr_q;
    logic [7:0]         data_q;
    int                 starts;
    int                 stops;
    int                 errs_now;

    function automatic logic [7:0] initial_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ {5'b0, a[10:8]} ^ 8'h5a;
    endfunction

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAIL %s expected 0x%0h got 0x%0h", name, expected, actual);
        errs_now = errs_now + 1;
    endtask

    task automatic protocol_error(input string what);
        $display("ERROR %s", what);
        errs_now = errs_now + 1;
    endtask

    assign peek_addr = addr_q;

    always @(posedge CLK)
    begin : watch
        logic bus_start;
        logic bus_stop;
        int   exp_starts;
        errs_now  = 0;
        bus_start = scl && scl_q && sda_q && !sda;
        bus_stop  = scl && scl_q && !sda_q && sda;
        exp_starts = is_wr ? 1 : 2;
        scl_q <= scl;
        sda_q <= sda;
        ack_q <= ack;
        if (RESET)
        begin
            for (int i = 0; i < DEPTH; i++)
                shadow[i] <= initial_byte(ADDR_W'(i));
            active   <= 1'b0;
            seen_req <= 1'b0;
            is_wr    <= 1'b0;
            addr_q   <= '0;
            starts   <= 0;
            stops    <= 0;
        end
        else
        begin
            // idle values before the first request
            if (!seen_req && !(wr || rd))
            begin
                if (ack != 1'b0)
                    value_mismatch("ack", 32'(1'b0), 32'(ack));
                if (scl != 1'b1)
                    value_mismatch("scl", 32'(1'b1), 32'(scl));
                if (sda_low != 1'b0)
                    value_mismatch("sda_low", 32'(1'b0), 32'(sda_low));
            end

            if (scl != scl_q && sda != sda_q)
                protocol_error("SDA changed in the same cycle as an SCL edge");
            if ((bus_start || bus_stop) && !active)
                protocol_error("start or stop condition outside a transaction");
            if (bus_start && stops != 0)
                protocol_error("start condition after the stop of a transaction");
            if (bus_start)
                starts <= starts + 1;
            if (bus_stop)
                stops <= stops + 1;
            if (ctrl_bad)
                protocol_error("control byte with a wrong device code");
            if (ack && ack_q)
                protocol_error("ack high for more than one cycle");
            if (ack && !active && !ack_q)
                protocol_error("ack without a pending request");

            if (ack && active)
            begin
                active <= 1'b0;
                if (is_wr)
                begin
                    shadow[addr_q] <= data_q;
                    if (peek_data != data_q)
                        value_mismatch("eeprom_model.mem", 32'(data_q), 32'(peek_data));
                end
                else if (rd_data != shadow[addr_q])
                begin
                    value_mismatch("rd_data", 32'(shadow[addr_q]), 32'(rd_data));
                end
                if (starts != exp_starts)
                    protocol_error("wrong number of start conditions in the transaction");
                if (stops != 1)
                    protocol_error("transaction did not end with exactly one stop");
            end
            else if (!active && (wr || rd))
            begin
                active   <= 1'b1;
                seen_req <= 1'b1;
                is_wr    <= wr;     // wr wins over rd
                addr_q   <= addr;
                data_q   <= wr_data;
                starts   <= 0;
                stops    <= 0;
            end
        end
        if (RESET)
            err_count <= 0;
        else
            err_count <= err_count + errs_now;
    end

endmodule

`default_nettype wire

/* testbench/eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_settings.svh"

module eeprom_model
(
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        scl,
    input  wire                        sda,
    output logic                       pull_low,
    output logic                       ctrl_bad,
    input  wire [`EEPROM_ADDR_W-1:0]   peek_addr,
    output logic [`EEPROM_DATA_W-1:0]  peek_data
);

    localparam int ADDR_W = `EEPROM_ADDR_W;
    localparam int DEPTH  = 1 << ADDR_W;

    logic [7:0]         mem [0:DEPTH-1];
    logic               scl_q;
    logic               sda_q;
    logic [7:0]         shift_in;
    logic [7:0]         shift_out;
    logic [3:0]         bit_cnt;
    logic [1:0]         byte_idx;   // 0 control, 1 word address, 2 data
    logic               reading;
    logic [2:0]         block;
    logic [ADDR_W-1:0]  ptr;

    // power-up contents fold in the block bits
    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ {5'b0, a[10:8]} ^ 8'h5a;
    endfunction

    assign peek_data = mem[peek_addr];

    // bus sampled on CLK and edges found against last cycle's values
    always @(posedge CLK)
    begin : bus_slave
        logic [7:0]              byte_now;
        eeprom_pkg::ctrl_byte_u  ctrl;
        byte_now = {shift_in[6:0], sda};
        ctrl.raw = byte_now;
        scl_q    <= scl;
        sda_q    <= sda;
        ctrl_bad <= 1'b0;
        if (RESET)
        begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= fill_byte(ADDR_W'(i));
            pull_low <= 1'b0;
            reading  <= 1'b0;
            bit_cnt  <= '0;
            byte_idx <= '0;
            ptr      <= '0;
            block    <= '0;
        end
        else if (scl && scl_q && sda_q && !sda)
        begin
            bit_cnt  <= '0;     // start or repeated start
            byte_idx <= '0;
            reading  <= 1'b0;
            pull_low <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            bit_cnt  <= '0;     // stop
            reading  <= 1'b0;
            pull_low <= 1'b0;
        end
        else if (scl && !scl_q && !reading)
        begin
            shift_in <= byte_now;
            if (bit_cnt == 4'd7)
            begin
                bit_cnt <= '0;
                case (byte_idx)
                    2'd0:
                    begin
                        if (ctrl.fields.dev_code != 4'b1010)
                            ctrl_bad <= 1'b1;
                        block    <= ctrl.fields.block;
                        byte_idx <= 2'd1;
                        if (ctrl.fields.rw)
                        begin
                            reading   <= 1'b1;
                            shift_out <= mem[ptr];
                        end
                    end
                    2'd1:
                    begin
                        ptr      <= {block, byte_now};
                        byte_idx <= 2'd2;
                    end
                    default:
                    begin
                        mem[ptr] <= byte_now;
                        ptr      <= ptr + ADDR_W'(1);
                    end
                endcase
            end
            else
            begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
        else if (!scl && scl_q && reading)
        begin
            if (bit_cnt == 4'd8)
            begin
                pull_low <= 1'b0;   // let go of sda after the last bit
                reading  <= 1'b0;
                bit_cnt  <= '0;
                ptr      <= ptr + ADDR_W'(1);
            end
            else
            begin
                pull_low  <= !shift_out[7];
                shift_out <= {shift_out[6:0], 1'b0};
                bit_cnt   <= bit_cnt + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_eeprom.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_settings.svh"

module tb_eeprom;

    localparam int NUM_TXN     = 48;
    localparam int READ_CYCLES = 8 * 20 * `SCL_HALF_CYCLES;
    localparam int CYCLE_LIMIT = 2 * NUM_TXN * READ_CYCLES;

    logic                       CLK;
    logic                       RESET;
    logic                       wr;
    logic                       rd;
    logic [`EEPROM_ADDR_W-1:0]  addr;
    logic [`EEPROM_DATA_W-1:0]  wr_data;
    wire  [`EEPROM_DATA_W-1:0]  rd_data;
    wire                        ack;
    wire                        scl;
    wire                        sda_low;
    wire                        slave_pull;
    wire                        sda;
    wire                        ctrl_bad;
    wire  [`EEPROM_ADDR_W-1:0]  peek_addr;
    wire  [`EEPROM_DATA_W-1:0]  peek_data;
    int                         err_count;
    int                         cycle_count;

    assign sda = !(sda_low || slave_pull);  // open drain with pull-up

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // mostly a small pool so reads land on written bytes
    function automatic logic [`EEPROM_ADDR_W-1:0] pick_addr(input logic [31:0] r);
        if (r[31:30] == 2'b00)
            return r[26:16];
        case (r[29:27])
            3'd0:    return 11'h000;
            3'd1:    return 11'h0ff;
            3'd2:    return 11'h100;
            3'd3:    return 11'h2a5;
            3'd4:    return 11'h3ff;
            3'd5:    return 11'h555;
            3'd6:    return 11'h7fe;
            default: return 11'h7ff;
        endcase
    endfunction

    eeprom_top i_eeprom_top (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    eeprom_model i_eeprom_model (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda),
        .pull_low  (slave_pull),
        .ctrl_bad  (ctrl_bad),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

    eeprom_checker i_eeprom_checker (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .ack       (ack),
        .scl       (scl),
        .sda       (sda),
        .sda_low   (sda_low),
        .ctrl_bad  (ctrl_bad),
        .peek_addr (peek_addr),
        .peek_data (peek_data),
        .err_count (err_count)
    );

    initial
    begin
        CLK = 1'b0;
    end

    always #4 CLK = !CLK;

    always @(posedge CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: no ack from the DUT after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin : stimulus
        logic [31:0]                rng;
        logic                       is_write;
        logic [`EEPROM_ADDR_W-1:0]  txn_addr;
        logic [`EEPROM_DATA_W-1:0]  txn_data;
        int                         idle_cycles;
        int                         errs_before;
        int                         passed;
        int                         failed;
        string                      kind;
        rng     = 32'h93ce_d5b2;
        passed  = 0;
        failed  = 0;
        RESET   <= 1'b1;
        wr      <= 1'b0;
        rd      <= 1'b0;
        addr    <= '0;
        wr_data <= '0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        repeat (3) @(posedge CLK);

        if (err_count == 0)
        begin
            passed = passed + 1;
            $display("test reset: pass");
        end
        else
        begin
            failed = failed + 1;
            $display("test reset: fail");
        end

        for (int n = 0; n < NUM_TXN; n++)
        begin
            rng         = lcg_step(rng);
            is_write    = rng[16];
            rng         = lcg_step(rng);
            txn_addr    = pick_addr(rng);
            rng         = lcg_step(rng);
            txn_data    = rng[23:16];
            rng         = lcg_step(rng);
            idle_cycles = int'(rng[25:24]);
            errs_before = err_count;

            wr      <= is_write;
            rd      <= !is_write;
            addr    <= txn_addr;
            wr_data <= txn_data;
            @(posedge CLK);
            while (!ack)
                @(posedge CLK);
            wr <= 1'b0;
            rd <= 1'b0;
            @(posedge CLK);     // checker result of the ack cycle is in

            if (is_write)
                kind = "write";
            else
                kind = "read";
            if (err_count == errs_before)
            begin
                passed = passed + 1;
                $display("test %0d %s addr 0x%h: pass", n, kind, txn_addr);
            end
            else
            begin
                failed = failed + 1;
                $display("test %0d %s addr 0x%h: fail", n, kind, txn_addr);
            end
            repeat (idle_cycles) @(posedge CLK);
        end

        @(posedge CLK);
        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0 && err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
